/* bench/tb_tcdm_interconnect.sv */
// TCDM interconnect testbench
`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_interconnect import tcdm_pkg::*; ();

  localparam int          NbMasters    = 4;
  localparam int          NbBanks      = 4;
  localparam int          AddrMemWidth = 8;
  localparam int          BankBits     = $clog2(NbBanks);
  localparam int          Depth        = 1 << AddrMemWidth;
  localparam int          NbWords      = NbBanks * Depth;
  localparam int          ClkPeriod    = 4;
  localparam logic [31:0] LfsrSeed     = 32'ha16c69be;
  localparam int          GntTimeout   = 4 * NbMasters + 4;   // Cycles per batch

  logic clk_i;
  logic rst_ni;
  logic  [NbMasters-1:0] req, wen, gnt, r_valid;
  addr_t [NbMasters-1:0] addr;
  data_t [NbMasters-1:0] wdata, r_rdata;
  be_t   [NbMasters-1:0] be;
  logic  [NbBanks-1:0]   bank_req, bank_wen;
  logic  [NbBanks-1:0][AddrMemWidth-1:0] bank_addr;
  data_t [NbBanks-1:0]   bank_wdata, bank_rdata;
  be_t   [NbBanks-1:0]   bank_be;

  // One pending operation per master
  addr_t op_addr [NbMasters];
  logic  op_write [NbMasters];
  data_t op_wdata [NbMasters];
  be_t   op_be [NbMasters];

  data_t       ref_mem [NbWords];   // Expected contents by word address
  logic [31:0] lfsr_state;
  int          errors, tests_clean, tests_failing;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  tcdm_interconnect #(
    .NB_MASTERS     ( NbMasters    ),
    .NB_BANKS       ( NbBanks      ),
    .ADDR_MEM_WIDTH ( AddrMemWidth )
  ) u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .req_i (req), .addr_i (addr), .wen_i (wen), .wdata_i (wdata), .be_i (be),
    .gnt_o (gnt), .r_valid_o (r_valid), .r_rdata_o (r_rdata),
    .bank_req_o (bank_req), .bank_addr_o (bank_addr), .bank_wen_o (bank_wen),
    .bank_wdata_o (bank_wdata), .bank_be_o (bank_be), .bank_rdata_i (bank_rdata)
  );

  tcdm_sram_model #(
    .NB_BANKS       ( NbBanks      ),
    .ADDR_MEM_WIDTH ( AddrMemWidth )
  ) u_sram (
    .clk_i (clk_i), .req_i (bank_req), .addr_i (bank_addr), .wen_i (bank_wen),
    .wdata_i (bank_wdata), .be_i (bank_be), .rdata_o (bank_rdata)
  );

  // ************************************************************
  // Helpers
  // ************************************************************

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};   // One step per bit
    end
    return v;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t en);
    data_t r;
    r = old_w;
    for (int i = 0; i < BeWidth; i++)
      if (en[i])
        r[8*i +: 8] = new_w[8*i +: 8];
    return r;
  endfunction

  function automatic int count_ones(input logic [NbMasters-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < NbMasters; i++)
      n += int'(v[i]);
    return n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic set_op(input int m, input int word, input logic write, input data_t d,
                        input be_t en);
    op_addr[m]  = addr_t'(word % NbWords) << ByteOffset;
    op_write[m] = write;
    op_wdata[m] = d;
    op_be[m]    = en;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
    begin
      tests_clean++;
      $display("%-14s : clean", name);
    end
    else
    begin
      tests_failing++;
      $display("%-14s : %0d errors", name, errors - err_before);
    end
  endtask

  // Runs the ops of the active masters until all are granted and answered
  task automatic issue_batch(input logic [NbMasters-1:0] active, output int gnt_cycles,
                             output int max_gnts);
    logic [NbMasters-1:0] pending, last_gnt, now_gnt;
    logic [NbBanks-1:0]   exp_bank_req;
    data_t                exp_rdata [NbMasters];
    int                   waited, word, b;
    pending    = active;
    last_gnt   = '0;
    waited     = 0;
    gnt_cycles = 0;
    max_gnts   = 0;
    while ((pending != '0 || last_gnt != '0) && waited < GntTimeout)
    begin
      @(negedge clk_i);
      req = pending;
      for (int m = 0; m < NbMasters; m++)
      begin
        addr[m]  = op_addr[m];
        wen[m]   = ~op_write[m];
        wdata[m] = op_wdata[m];
        be[m]    = op_be[m];
      end
      #1;
      // Answers to last cycle's grants
      for (int m = 0; m < NbMasters; m++)
      begin
        check_value($sformatf("r_valid_o[%0d]", m), r_valid[m], last_gnt[m]);
        if (last_gnt[m] && !op_write[m])
          check_value($sformatf("r_rdata_o[%0d]", m), r_rdata[m], exp_rdata[m]);
      end
      now_gnt = gnt;
      check_value("gnt_o without req", now_gnt & ~pending, '0);
      now_gnt      = now_gnt & pending;
      exp_bank_req = '0;
      for (int m = 0; m < NbMasters; m++)
      begin
        if (now_gnt[m])
        begin
          word = int'(op_addr[m] >> ByteOffset) % NbWords;
          b    = word % NbBanks;            // Low word bits pick the bank
          exp_bank_req[b] = 1'b1;
          check_value($sformatf("bank_addr_o[%0d]", b), bank_addr[b], word / NbBanks);
          check_value($sformatf("bank_wen_o[%0d]", b), bank_wen[b], !op_write[m]);
          check_value($sformatf("bank_be_o[%0d]", b), bank_be[b], op_be[m]);
          if (op_write[m])
            check_value($sformatf("bank_wdata_o[%0d]", b), bank_wdata[b], op_wdata[m]);
          exp_rdata[m] = ref_mem[word];
          if (op_write[m])
            ref_mem[word] = merge_bytes(ref_mem[word], op_wdata[m], op_be[m]);
        end
      end
      check_value("bank_req_o", bank_req, exp_bank_req);
      if (pending != '0)
        gnt_cycles++;
      if (count_ones(now_gnt) > max_gnts)
        max_gnts = count_ones(now_gnt);
      last_gnt = now_gnt;
      pending  = pending & ~now_gnt;
      waited++;
    end
    for (int m = 0; m < NbMasters; m++)
    begin
      if (pending[m])
      begin
        errors++;
        $display("Timeout at %0t: master %0d got no gnt_o within %0d cycles",
                 $time, m, GntTimeout);
      end
    end
    if (pending != '0)
    begin
      @(negedge clk_i);
      req = '0;
    end
  endtask

  // ************************************************************
  // Tests
  // ************************************************************

  task automatic test_reset();
    int err_before;
    err_before = errors;
    for (int c = 0; c < 6; c++)
    begin
      @(negedge clk_i);
      if (c == 3)
        rst_ni = 1'b1;   // Held low over four rising edges
      #1;
      check_value("gnt_o", gnt, '0);
      check_value("r_valid_o", r_valid, '0);
      check_value("bank_req_o", bank_req, '0);
    end
    report_test("reset state", err_before);
  endtask

  // Every master hits its own bank, all in one cycle
  task automatic test_parallel();
    int err_before, gc, mg;
    err_before = errors;
    for (int round = 0; round < NbBanks; round++)
    begin
      for (int m = 0; m < NbMasters; m++)
        set_op(m, int'(rand_bits(AddrMemWidth)) * NbBanks + (m + round) % NbBanks, 1'b1,
               rand_bits(32), '1);
      issue_batch('1, gc, mg);
      check_value("write grant cycles", gc, 1);
      for (int m = 0; m < NbMasters; m++)
        op_write[m] = 1'b0;
      issue_batch('1, gc, mg);
      check_value("read grant cycles", gc, 1);
    end
    report_test("parallel", err_before);
  endtask

  task automatic test_interleave();
    int err_before, gc, mg, base;
    err_before = errors;
    base = int'(rand_bits(AddrMemWidth)) * NbBanks;
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int w = 0; w < 2 * NbBanks; w++)
      begin
        set_op(2, base + w, pass == 0, rand_bits(32), '1);   // Writes first, then reads
        issue_batch(4'b0100, gc, mg);
        check_value("grant cycles", gc, 1);
      end
    end
    report_test("interleave", err_before);
  endtask

  task automatic test_byte_enables();
    int  err_before, gc, mg, word;
    be_t masks [5];
    err_before = errors;
    masks = '{4'b1111, 4'b0001, 4'b0110, 4'b1000, 4'b0101};
    word  = int'(rand_bits(AddrMemWidth + BankBits));
    foreach (masks[i])
    begin
      set_op(1, word, 1'b1, rand_bits(32), masks[i]);
      issue_batch(4'b0010, gc, mg);
      op_write[1] = 1'b0;
      issue_batch(4'b0010, gc, mg);   // Merge is checked against ref_mem
    end
    report_test("byte enables", err_before);
  endtask

  // All masters on one bank, one grant per cycle
  task automatic test_conflict();
    int err_before, gc, mg, bank, row;
    err_before = errors;
    for (int round = 0; round < 2; round++)
    begin
      bank = int'(rand_bits(BankBits));
      row  = int'(rand_bits(AddrMemWidth));
      for (int m = 0; m < NbMasters; m++)
        set_op(m, ((row + m) % Depth) * NbBanks + bank, 1'b1, rand_bits(32), '1);
      for (int pass = 0; pass < 2; pass++)
      begin
        issue_batch('1, gc, mg);
        check_value("grant cycles", gc, NbMasters);
        check_value("grants per cycle", mg, 1);
        for (int m = 0; m < NbMasters; m++)
          op_write[m] = 1'b0;
      end
    end
    report_test("conflict", err_before);
  endtask

  initial
  begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req           = '0;
    addr          = '0;
    wen           = '1;
    wdata         = '0;
    be            = '0;
    lfsr_state    = LfsrSeed;
    errors        = 0;
    tests_clean   = 0;
    tests_failing = 0;
    for (int m = 0; m < NbMasters; m++)
      set_op(m, 0, 1'b0, '0, '0);
    test_reset();
    test_parallel();
    test_interleave();
    test_byte_enables();
    test_conflict();
    $display("Tests: %0d clean, %0d failing, %0d errors", tests_clean, tests_failing, errors);
    if (errors == 0 && tests_failing == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule : tb_tcdm_interconnect

`default_nettype wire

/* bench/tcdm_sram_model.sv */
// Behavioural SRAM banks
`timescale 1ns/100ps
`default_nettype none

module tcdm_sram_model import tcdm_pkg::*; #(
  parameter int unsigned NB_BANKS       = 4,
  parameter int unsigned ADDR_MEM_WIDTH = 8
) (
  input  logic                                   clk_i,
  input  logic  [NB_BANKS-1:0]                   req_i,
  input  logic  [NB_BANKS-1:0][ADDR_MEM_WIDTH-1:0] addr_i,
  input  logic  [NB_BANKS-1:0]                   wen_i,    // Low for a write
  input  data_t [NB_BANKS-1:0]                   wdata_i,
  input  be_t   [NB_BANKS-1:0]                   be_i,
  output data_t [NB_BANKS-1:0]                   rdata_o   // One cycle after req
);

  localparam int unsigned Depth = 1 << ADDR_MEM_WIDTH;

  data_t mem [NB_BANKS][Depth];

  // Fill derived from bank and row, so stale reads are easy to spot
  initial
  begin
    for (int b = 0; b < int'(NB_BANKS); b++)
    begin
      for (int a = 0; a < int'(Depth); a++)
        mem[b][a] = data_t'((b * Depth + a) * 32'h9e37_79b1);
    end
  end

  always @(posedge clk_i)
  begin
    for (int b = 0; b < int'(NB_BANKS); b++)
    begin
      if (req_i[b])
      begin
        if (!wen_i[b])
        begin
          for (int i = 0; i < int'(BeWidth); i++)
            if (be_i[b][i])
              mem[b][addr_i[b]][8*i +: 8] <= wdata_i[b][8*i +: 8];
        end
        rdata_o[b] <= mem[b][addr_i[b]];   // Old contents on a write
      end
    end
  end

endmodule : tcdm_sram_model

`default_nettype wire

/* hw/rr_arbiter.sv */
// Round-robin arbiter
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned N = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic [N-1:0] req_i,
  output logic [N-1:0] gnt_o,
  input  logic         ack_i   // Winner was taken, move the pointer on
);

  localparam int unsigned IdxW = (N > 1) ? $clog2(N) : 1;

  logic [IdxW-1:0] ptr_q;       // Requester with the highest priority
  logic [IdxW-1:0] ptr_next;
  logic [IdxW-1:0] winner_idx;
  logic            found;
  int              cand;

  // ********************************************************
  // Grant selection
  // ********************************************************

  // Scan starts at the pointer and wraps around once
  always_comb
  begin
    gnt_o      = '0;
    winner_idx = '0;
    found      = 1'b0;
    cand       = 0;
    for (int i = 0; i < int'(N); i++)
    begin
      cand = int'(ptr_q) + i;
      if (cand >= int'(N))
        cand = cand - int'(N);   // Wrap
      if (!found && req_i[cand])
      begin
        gnt_o[cand] = 1'b1;
        winner_idx  = IdxW'(cand);
        found       = 1'b1;
      end
    end
  end

  // One past the winner, so it gets the lowest priority next time
  assign ptr_next = (winner_idx == IdxW'(N - 1)) ? '0 : winner_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ptr_q <= '0;
    else if (ack_i && found)
      ptr_q <= ptr_next;
  end

  // ********************************************************
  // Checks
  // ********************************************************

  // A grant is one-hot and only ever goes to an active requester
  a_gnt_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("Arbiter grant %b does not match requests %b", gnt_o, req_i);

endmodule : rr_arbiter

`default_nettype wire

/* hw/tcdm_bank_port.sv */
// TCDM bank request port
`timescale 1ns/100ps
`default_nettype none

module tcdm_bank_port import tcdm_pkg::*; #(
  parameter int unsigned NB_MASTERS     = 4,
  parameter int unsigned NB_BANKS       = 4,
  parameter int unsigned BANK_IDX       = 0,
  parameter int unsigned ADDR_MEM_WIDTH = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Master requests, all masters
  input  logic  [NB_MASTERS-1:0]        req_i,
  input  addr_t [NB_MASTERS-1:0]        addr_i,
  input  logic  [NB_MASTERS-1:0]        wen_i,     // Low for a write
  input  data_t [NB_MASTERS-1:0]        wdata_i,
  input  be_t   [NB_MASTERS-1:0]        be_i,
  output logic  [NB_MASTERS-1:0]        gnt_o,

  // Towards the SRAM bank
  output logic                          bank_req_o,
  output logic  [ADDR_MEM_WIDTH-1:0]    bank_addr_o,
  output logic                          bank_wen_o,
  output data_t                         bank_wdata_o,
  output be_t                           bank_be_o,

  // Response identity, one cycle after the access
  output logic                          resp_valid_o,
  output logic  [NB_MASTERS-1:0]        resp_id_o
);

  localparam int unsigned BankBits = $clog2(NB_BANKS);
  localparam int unsigned MemLsb   = ByteOffset + BankBits;  // First word-address bit
  localparam addr_t       BankMask = addr_t'(NB_BANKS - 1);

  logic [NB_MASTERS-1:0] bank_hit;   // Masters that address this bank

  // ********************************************************
  // Address decode and arbitration
  // ********************************************************

  for (genvar m = 0; m < NB_MASTERS; m++)
  begin : g_decode
    assign bank_hit[m] = req_i[m] &&
                         (((addr_i[m] >> ByteOffset) & BankMask) == addr_t'(BANK_IDX));
  end

  rr_arbiter #(
    .N      ( NB_MASTERS )
  ) u_arb (
    .clk_i  ( clk_i      ),
    .rst_ni ( rst_ni     ),
    .req_i  ( bank_hit   ),
    .gnt_o  ( gnt_o      ),
    .ack_i  ( bank_req_o )
  );

  // Bank never stalls, any grant is an access
  assign bank_req_o = |gnt_o;

  // Winner's fields onto the bank
  always_comb
  begin
    bank_addr_o  = '0;
    bank_wen_o   = 1'b1;   // Read when idle
    bank_wdata_o = '0;
    bank_be_o    = '0;
    for (int m = 0; m < int'(NB_MASTERS); m++)
    begin
      if (gnt_o[m])
      begin
        bank_addr_o  = addr_i[m][MemLsb +: ADDR_MEM_WIDTH];
        bank_wen_o   = wen_i[m];
        bank_wdata_o = wdata_i[m];
        bank_be_o    = be_i[m];
      end
    end
  end

  // ********************************************************
  // Response identity
  // ********************************************************

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      resp_valid_o <= 1'b0;
      resp_id_o    <= '0;
    end
    else
    begin
      resp_valid_o <= bank_req_o;   // Writes get a response too
      if (bank_req_o)
        resp_id_o <= gnt_o;         // Kept while the bank is idle
    end
  end

  // Every response belongs to an access of the previous cycle
  a_resp_follows_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> $past(bank_req_o))
    else $error("Bank %0d responds without an access", BANK_IDX);

endmodule : tcdm_bank_port

`default_nettype wire

/* hw/tcdm_interconnect.sv */
// TCDM logarithmic interconnect
`timescale 1ns/100ps
`default_nettype none

module tcdm_interconnect import tcdm_pkg::*; #(
  parameter int unsigned NB_MASTERS     = 4,
  parameter int unsigned NB_BANKS       = 4,   // Power of two
  parameter int unsigned ADDR_MEM_WIDTH = 8    // Words per bank, log2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  // ********************************************************
  // Master side
  // ********************************************************
  input  logic  [NB_MASTERS-1:0]                  req_i,
  input  addr_t [NB_MASTERS-1:0]                  addr_i,
  input  logic  [NB_MASTERS-1:0]                  wen_i,      // Active low write
  input  data_t [NB_MASTERS-1:0]                  wdata_i,
  input  be_t   [NB_MASTERS-1:0]                  be_i,
  output logic  [NB_MASTERS-1:0]                  gnt_o,
  output logic  [NB_MASTERS-1:0]                  r_valid_o,
  output data_t [NB_MASTERS-1:0]                  r_rdata_o,

  // ********************************************************
  // SRAM bank side
  // ********************************************************
  output logic  [NB_BANKS-1:0]                    bank_req_o,
  output logic  [NB_BANKS-1:0][ADDR_MEM_WIDTH-1:0] bank_addr_o,
  output logic  [NB_BANKS-1:0]                    bank_wen_o,
  output data_t [NB_BANKS-1:0]                    bank_wdata_o,
  output be_t   [NB_BANKS-1:0]                    bank_be_o,
  input  data_t [NB_BANKS-1:0]                    bank_rdata_i   // One cycle after req
);

  logic [NB_BANKS-1:0][NB_MASTERS-1:0] bank_gnt;     // Grants given by each bank
  logic [NB_BANKS-1:0]                 resp_valid;
  logic [NB_BANKS-1:0][NB_MASTERS-1:0] resp_id;

  // One request port per bank
  for (genvar b = 0; b < NB_BANKS; b++)
  begin : g_bank
    tcdm_bank_port #(
      .NB_MASTERS     ( NB_MASTERS     ),
      .NB_BANKS       ( NB_BANKS       ),
      .BANK_IDX       ( b              ),
      .ADDR_MEM_WIDTH ( ADDR_MEM_WIDTH )
    ) u_bank_port (
      .clk_i          ( clk_i           ),
      .rst_ni         ( rst_ni          ),
      .req_i          ( req_i           ),
      .addr_i         ( addr_i          ),
      .wen_i          ( wen_i           ),
      .wdata_i        ( wdata_i         ),
      .be_i           ( be_i            ),
      .gnt_o          ( bank_gnt[b]     ),
      .bank_req_o     ( bank_req_o[b]   ),
      .bank_addr_o    ( bank_addr_o[b]  ),
      .bank_wen_o     ( bank_wen_o[b]   ),
      .bank_wdata_o   ( bank_wdata_o[b] ),
      .bank_be_o      ( bank_be_o[b]    ),
      .resp_valid_o   ( resp_valid[b]   ),
      .resp_id_o      ( resp_id[b]      )
    );
  end

  // A master addresses one bank, so at most one of these is set per master
  always_comb
  begin
    gnt_o = '0;
    for (int b = 0; b < int'(NB_BANKS); b++)
      gnt_o = gnt_o | bank_gnt[b];
  end

  tcdm_resp_router #(
    .NB_MASTERS   ( NB_MASTERS   ),
    .NB_BANKS     ( NB_BANKS     )
  ) u_resp_router (
    .resp_valid_i ( resp_valid   ),
    .resp_id_i    ( resp_id      ),
    .bank_rdata_i ( bank_rdata_i ),
    .r_valid_o    ( r_valid_o    ),
    .r_rdata_o    ( r_rdata_o    )
  );

endmodule : tcdm_interconnect

`default_nettype wire

/* hw/tcdm_pkg.sv */
// TCDM bus definitions
`default_nettype none

package tcdm_pkg;

  // ********************************************************
  // Bus widths
  // ********************************************************

  localparam int unsigned DataWidth = 32;            // Bus data width
  localparam int unsigned AddrWidth = 32;            // Master byte address width
  localparam int unsigned BeWidth   = DataWidth / 8; // One enable per byte

  // Low address bits that pick a byte inside a word
  localparam int unsigned ByteOffset = $clog2(BeWidth);

  // ********************************************************
  // Word types
  // ********************************************************

  typedef logic [DataWidth-1:0] data_t;  // Read or write data word
  typedef logic [AddrWidth-1:0] addr_t;  // Master address
  typedef logic [BeWidth-1:0]   be_t;    // Byte enables

  // Address layout seen from a master, low to high:
  //   byte offset    ByteOffset bits
  //   bank index     log2(NB_BANKS) bits
  //   word address   ADDR_MEM_WIDTH bits, local to the bank
  // Consecutive words therefore fall into consecutive banks

endpackage : tcdm_pkg

`default_nettype wire

/* hw/tcdm_resp_router.sv */
// TCDM response router
`timescale 1ns/100ps
`default_nettype none

module tcdm_resp_router import tcdm_pkg::*; #(
  parameter int unsigned NB_MASTERS = 4,
  parameter int unsigned NB_BANKS   = 4
) (
  input  logic [NB_BANKS-1:0]                  resp_valid_i,
  input  logic [NB_BANKS-1:0][NB_MASTERS-1:0]  resp_id_i,     // One-hot per bank
  input  data_t [NB_BANKS-1:0]                 bank_rdata_i,
  output logic [NB_MASTERS-1:0]                r_valid_o,
  output data_t [NB_MASTERS-1:0]               r_rdata_o
);

  // Bank b answers master m
  logic [NB_MASTERS-1:0][NB_BANKS-1:0] hit;

  always_comb
  begin
    for (int m = 0; m < int'(NB_MASTERS); m++)
    begin
      for (int b = 0; b < int'(NB_BANKS); b++)
        hit[m][b] = resp_valid_i[b] & resp_id_i[b][m];
    end
  end

  // ********************************************************
  // Per-master response select
  // ********************************************************

  always_comb
  begin
    r_valid_o = '0;
    r_rdata_o = '0;   // Zero data without a response
    for (int m = 0; m < int'(NB_MASTERS); m++)
    begin
      for (int b = 0; b < int'(NB_BANKS); b++)
      begin
        if (hit[m][b])
        begin
          r_valid_o[m] = 1'b1;
          r_rdata_o[m] = bank_rdata_i[b];
        end
      end
    end
  end

  // One grant per master and cycle means one response per master and cycle
  always_comb
  begin
    for (int m = 0; m < int'(NB_MASTERS); m++)
    begin
      a_one_resp : assert final ($onehot0(hit[m]))
        else $error("Master %0d gets responses from banks %b", m, hit[m]);
    end
  end

endmodule : tcdm_resp_router

`default_nettype wire

/* project.f */
hw/tcdm_pkg.sv
hw/rr_arbiter.sv
hw/tcdm_bank_port.sv
hw/tcdm_resp_router.sv
hw/tcdm_interconnect.sv
bench/tcdm_sram_model.sv
bench/tb_tcdm_interconnect.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tcdm_interconnect -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_tcdm_interconnect)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
